// ==== project.f ====
+incdir+hw
hw/ooo_data_pkg.sv
hw/ooo_ctrl_pkg.sv
hw/ooo_ifs.sv
hw/dispatch_unit.sv
hw/map_table.sv
hw/arch_regfile.sv
hw/reservation_station.sv
hw/alu_unit.sv
hw/rob.sv
hw/ooo_core.sv
test/ooo_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the simulator from the file list, run it and look for the pass line in its log.
verilator --binary --timing -Wno-fatal --top-module ooo_core_tb -f project.f \
    -o ooo_core_sim > build.log 2>&1 \
    && ./obj_dir/ooo_core_sim | tee sim.log \
    && grep -qx "TEST OK" sim.log \
    && echo "Simulation passed." \
    || { echo "Simulation failed, see build.log and sim.log."; exit 1; }

// ==== test/ooo_core_tb.sv ====
`default_nettype none

`include "ooo_macros.svh"

module ooo_core_tb;
    import ooo_data_pkg::*;
    import ooo_ctrl_pkg::*;

    localparam int DRIVE_DELAY = 2;         // Inputs change shortly after the rising edge.
    localparam int RESET_CYCLES = 16;

    typedef struct packed {
        alu_op_t  op;
        reg_idx_t dest;
        reg_idx_t src1;
        reg_idx_t src2;
        logic     wrong_path;               // Follows a mispredicted branch and must not commit.
    } entry_t;

    logic     clock;
    logic     reset;
    logic     dispatch_valid;
    pc_t      dispatch_pc;
    alu_op_t  dispatch_op;
    reg_idx_t dispatch_dest;
    reg_idx_t dispatch_src1;
    reg_idx_t dispatch_src2;
    logic     stall;
    logic     commit_valid;
    logic     squash;
    reg_idx_t commit_reg;
    word_t    commit_value;

    entry_t   program_table [$];
    logic     mispredicts [$];              // One flag per table entry.
    reg_idx_t exp_regs [$];
    word_t    exp_values [$];
    int       errors = 0;
    int       commits_seen = 0;
    int       squashes_seen = 0;
    int       squashes_expected = 0;
    int       stall_cycles = 0;
    int       cycles = 0;
    int       cycle_limit = 0;

    ooo_core uut (
        .clock(clock), .reset(reset), .dispatch_valid(dispatch_valid),
        .dispatch_pc(dispatch_pc), .dispatch_op(dispatch_op),
        .dispatch_dest(dispatch_dest), .dispatch_src1(dispatch_src1),
        .dispatch_src2(dispatch_src2), .stall(stall), .commit_valid(commit_valid),
        .squash(squash), .commit_reg(commit_reg), .commit_value(commit_value)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // Starting register contents, every bit of the index shows up in the value.
    function automatic word_t initial_value(input int idx);
        logic [7:0] b;
        b = 8'(idx);
        return {b * 8'h1d, b ^ 8'hc3, b + 8'h40, b};
    endfunction

    task automatic append_entry(input alu_op_t op, input int dest, input int src1,
                                input int src2, input logic wrong_path);
        program_table.push_back(entry_t'{op, reg_idx_t'(dest), reg_idx_t'(src1),
                                         reg_idx_t'(src2), wrong_path});
    endtask

    task automatic build_table();
        append_entry(op_add, 10, 1, 2, 1'b0);   // Independent operations.
        append_entry(op_sub, 11, 3, 4, 1'b0);
        append_entry(op_xor, 12, 5, 6, 1'b0);
        append_entry(op_add, 13, 7, 8, 1'b0);
        append_entry(op_add, 14, 10, 11, 1'b0); // Dependent chain.
        append_entry(op_sub, 15, 14, 12, 1'b0);
        append_entry(op_xor, 16, 15, 14, 1'b0);
        append_entry(op_add, 17, 16, 13, 1'b0);
        append_entry(op_add, 20, 20, 1, 1'b0);  // Serial chain that backs up the window.
        append_entry(op_sub, 20, 20, 2, 1'b0);
        append_entry(op_xor, 20, 20, 3, 1'b0);
        append_entry(op_add, 20, 20, 4, 1'b0);
        append_entry(op_add, 21, 20, 20, 1'b0);
        append_entry(op_xor, 21, 21, 6, 1'b0);
        append_entry(op_add, 22, 7, 9, 1'b0);   // Free to issue ahead of the chain.
        append_entry(op_add, 0, 1, 2, 1'b0);
        append_entry(op_add, 23, 0, 3, 1'b0);
        append_entry(op_xor, 24, 0, 0, 1'b0);
        append_entry(op_sub, 0, 24, 23, 1'b0);
        append_entry(op_bne, 0, 1, 1, 1'b0);    // Falls through.
        append_entry(op_bne, 0, 24, 0, 1'b0);
        append_entry(op_bne, 0, 1, 2, 1'b0);    // Taken, so mispredicted.
        append_entry(op_add, 1, 2, 3, 1'b1);
        append_entry(op_xor, 25, 1, 1, 1'b1);
        append_entry(op_add, 25, 1, 21, 1'b0);
        append_entry(op_sub, 26, 25, 2, 1'b0);
        append_entry(op_bne, 0, 26, 0, 1'b0);
        append_entry(op_add, 26, 0, 0, 1'b1);
        append_entry(op_sub, 27, 26, 26, 1'b1);
        append_entry(op_add, 28, 26, 1, 1'b1);
        append_entry(op_xor, 27, 26, 1, 1'b0);
        append_entry(op_add, 28, 27, 25, 1'b0);
    endtask

    // Executes the correct path in program order and queues the commits it should see.
    task automatic run_model();
        word_t regs [`REG_COUNT];
        word_t a;
        word_t b;
        word_t result;
        regs[0] = '0;
        for (int r = 1; r < `REG_COUNT; r++) begin
            regs[r] = initial_value(r);
        end
        for (int i = 0; i < program_table.size(); i++) begin
            entry_t e;
            e = program_table[i];
            a = regs[e.src1];
            b = regs[e.src2];
            mispredicts.push_back(1'b0);
            case (e.op)
                op_add:  result = a + b;
                op_sub:  result = a - b;
                op_xor:  result = a ^ b;
                default: result = '0;
            endcase
            if (e.wrong_path) begin
                continue;
            end
            if (e.op == op_bne) begin
                mispredicts[i] = (a != b);
                squashes_expected += (a != b) ? 1 : 0;
            end else if (e.dest != 5'd0) begin
                regs[e.dest] = result;
                exp_regs.push_back(e.dest);
                exp_values.push_back(result);
            end
        end
    endtask

    task automatic preload_regfile();
        for (int r = 1; r < `REG_COUNT; r++) begin
            uut.u_regfile.regs[r] = initial_value(r);
        end
    endtask

    task automatic check_commit(input reg_idx_t got_reg, input word_t got_value);
        reg_idx_t want_reg;
        word_t    want_value;
        if (exp_regs.size() == 0) begin
            errors++;
            $display("Commit to r%0d at time %0t came after all expected commits.",
                     got_reg, $time);
            return;
        end
        want_reg = exp_regs.pop_front();
        want_value = exp_values.pop_front();
        if (got_reg !== want_reg) begin
            errors++;
            $display("CHECK FAILED time=%0t commit_reg expected=%0d got=%0d",
                     $time, want_reg, got_reg);
        end
        if (got_value !== want_value) begin
            errors++;
            $display("CHECK FAILED time=%0t commit_value expected=%08h got=%08h",
                     $time, want_value, got_value);
        end
    endtask

    task automatic check_squash(input int got_count, input int want_count);
        if (got_count != want_count) begin
            errors++;
            $display("CHECK FAILED time=%0t squash_count expected=%0d got=%0d",
                     $time, want_count, got_count);
        end
    endtask

    // All DUT outputs are settled by the falling edge.
    always @(negedge clock) begin
        if (!reset) begin
            stall_cycles += stall ? 1 : 0;
            squashes_seen += squash ? 1 : 0;
            if (commit_valid) begin
                commits_seen++;
                check_commit(commit_reg, commit_value);
            end
        end
    end

    initial begin
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge clock);
            cycles++;
        end
        $display("Timeout after %0d cycles with %0d commits still outstanding.",
                 cycles, exp_regs.size());
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        logic accepted;
        logic squash_pending;               // A mispredicted branch is in flight.
        logic squash_done;
        reset = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_pc = '0;
        dispatch_op = op_add;
        dispatch_dest = '0;
        dispatch_src1 = '0;
        dispatch_src2 = '0;
        build_table();
        run_model();
        cycle_limit = 40 * program_table.size() + 100;
        repeat (RESET_CYCLES) @(posedge clock);
        #DRIVE_DELAY;
        reset = 1'b0;
        preload_regfile();
        squash_pending = 1'b0;
        squash_done = 1'b0;
        for (int i = 0; i < program_table.size(); i++) begin
            entry_t e;
            e = program_table[i];
            accepted = 1'b0;
            dispatch_valid = 1'b1;
            dispatch_pc = 32'h100 + 32'(4 * i);
            dispatch_op = e.op;
            dispatch_dest = e.dest;
            dispatch_src1 = e.src1;
            dispatch_src2 = e.src2;
            // Wrong-path entries are only offered until the squash arrives.
            while (!accepted && !(e.wrong_path && squash_done)) begin
                @(negedge clock);
                accepted = !stall && !squash;
                if (squash && !squash_pending) begin
                    errors++;
                    $display("Squash at time %0t without a mispredicted branch in flight.",
                             $time);
                end
                squash_done = squash_done || squash;
                @(posedge clock);
                #DRIVE_DELAY;
            end
            dispatch_valid = 1'b0;
            if (mispredicts[i]) begin
                squash_pending = 1'b1;
                squash_done = 1'b0;
            end
            if (squash_pending && (i + 1 == program_table.size()
                                   || !program_table[i + 1].wrong_path)) begin
                while (!squash_done) begin
                    @(negedge clock);
                    squash_done = squash;
                    @(posedge clock);
                    #DRIVE_DELAY;
                end
                squash_pending = 1'b0;
            end
        end
        while (exp_regs.size() != 0) begin
            @(posedge clock);
        end
        repeat (10) @(posedge clock);       // Gives a stray commit time to show up.
        check_squash(squashes_seen, squashes_expected);
        if (stall_cycles == 0) begin
            errors++;
            $display("Stall never rose, so the full window was not reached.");
        end
        $display("Summary: %0d commits, %0d squashes, %0d stall cycles, %0d errors",
                 commits_seen, squashes_seen, stall_cycles, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/ooo_core.sv ====
`default_nettype none

module ooo_core (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    dispatch_valid,
    input  ooo_data_pkg::pc_t       dispatch_pc,
    input  ooo_ctrl_pkg::alu_op_t   dispatch_op,
    input  ooo_data_pkg::reg_idx_t  dispatch_dest,
    input  ooo_data_pkg::reg_idx_t  dispatch_src1,
    input  ooo_data_pkg::reg_idx_t  dispatch_src2,
    output logic                    stall,
    output logic                    commit_valid,
    output logic                    squash,
    output ooo_data_pkg::reg_idx_t  commit_reg,
    output ooo_data_pkg::word_t     commit_value
);
    import ooo_data_pkg::*;
    import ooo_ctrl_pkg::*;

    rob_idx_t map_tag1;
    rob_idx_t map_tag2;
    logic     map_hit1;
    logic     map_hit2;
    word_t    reg_value1;
    word_t    reg_value2;
    logic     rob_ready1;
    logic     rob_ready2;
    word_t    rob_value1;
    word_t    rob_value2;
    logic     rob_full;
    logic     rs_full;
    logic     issue_valid;
    alu_op_t  issue_op;
    word_t    issue_a;
    word_t    issue_b;
    rob_idx_t issue_tag;

    dispatch_if dsp ();
    complete_if cpl ();
    commit_if   cmt ();

    assign commit_valid = cmt.dest_valid;
    assign commit_reg = cmt.dest_reg_idx;
    assign commit_value = cmt.dest_value;

    dispatch_unit u_dispatch (
        .valid(dispatch_valid), .pc(dispatch_pc), .op(dispatch_op),
        .dest(dispatch_dest), .src1(dispatch_src1), .src2(dispatch_src2),
        .map_tag1(map_tag1), .map_tag2(map_tag2), .map_hit1(map_hit1), .map_hit2(map_hit2),
        .reg_value1(reg_value1), .reg_value2(reg_value2),
        .rob_ready1(rob_ready1), .rob_ready2(rob_ready2),
        .rob_value1(rob_value1), .rob_value2(rob_value2),
        .rob_full(rob_full), .rs_full(rs_full), .squash(squash), .stall(stall), .dsp(dsp)
    );

    map_table u_map (
        .clock(clock), .reset(reset), .squash(squash), .dsp(dsp), .cmt(cmt),
        .src1(dispatch_src1), .src2(dispatch_src2),
        .map_tag1(map_tag1), .map_tag2(map_tag2), .map_hit1(map_hit1), .map_hit2(map_hit2)
    );

    arch_regfile u_regfile (
        .clock(clock), .reset(reset), .cmt(cmt),
        .src1(dispatch_src1), .src2(dispatch_src2),
        .reg_value1(reg_value1), .reg_value2(reg_value2)
    );

    reservation_station u_rs (
        .clock(clock), .reset(reset), .squash(squash), .dsp(dsp), .cpl(cpl),
        .issue_valid(issue_valid), .issue_op(issue_op), .issue_a(issue_a),
        .issue_b(issue_b), .issue_tag(issue_tag), .rs_full(rs_full)
    );

    alu_unit u_alu (
        .clock(clock), .reset(reset), .squash(squash),
        .issue_valid(issue_valid), .issue_op(issue_op), .issue_a(issue_a),
        .issue_b(issue_b), .issue_tag(issue_tag), .cpl(cpl)
    );

    rob u_rob (
        .clock(clock), .reset(reset), .dsp(dsp), .cpl(cpl),
        .fwd_tag1(map_tag1), .fwd_tag2(map_tag2),
        .rob_ready1(rob_ready1), .rob_ready2(rob_ready2),
        .rob_value1(rob_value1), .rob_value2(rob_value2),
        .rob_full(rob_full), .squash(squash), .cmt(cmt)
    );

endmodule

`default_nettype wire

// ==== hw/rob.sv ====
`default_nettype none

`include "ooo_macros.svh"

module rob (
    input  logic                    clock,
    input  logic                    reset,
    dispatch_if.rob_side            dsp,
    complete_if.sink                cpl,
    input  ooo_data_pkg::rob_idx_t  fwd_tag1,
    input  ooo_data_pkg::rob_idx_t  fwd_tag2,
    output logic                    rob_ready1,
    output logic                    rob_ready2,
    output ooo_data_pkg::word_t     rob_value1,
    output ooo_data_pkg::word_t     rob_value2,
    output logic                    rob_full,
    output logic                    squash,
    commit_if.source                cmt
);
    import ooo_data_pkg::*;

    localparam int CNT_W = `ROB_IDX_LEN + 1;

    rob_idx_t             head;
    rob_idx_t             tail;
    logic [CNT_W-1:0]     count;
    logic [`ROB_SIZE-1:0] ready;
    logic [`ROB_SIZE-1:0] mis_pred;
    reg_idx_t             dest [`ROB_SIZE];
    word_t                value [`ROB_SIZE];
    logic                 retire;

    assign retire = (count != '0) && ready[head];
    assign squash = retire && mis_pred[head];   // The branch itself leaves no commit.
    assign rob_full = (count == CNT_W'(`ROB_SIZE));

    assign dsp.rob_tag = tail;

    // Completed values are forwarded to dispatch until the entry retires.
    assign rob_ready1 = ready[fwd_tag1];
    assign rob_ready2 = ready[fwd_tag2];
    assign rob_value1 = value[fwd_tag1];
    assign rob_value2 = value[fwd_tag2];

    assign cmt.dest_valid = retire && !mis_pred[head] && dest[head] != `ZERO_REG;
    assign cmt.dest_reg_idx = dest[head];
    assign cmt.dest_value = value[head];
    assign cmt.head_idx = head;

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            ready <= '0;
        end else begin
            if (dsp.fire) begin
                ready[tail] <= 1'b0;
                dest[tail] <= dsp.dest;
                tail <= tail + 1'b1;            // Wraps at ROB_SIZE.
            end
            if (cpl.completed) begin
                ready[cpl.entry_idx] <= 1'b1;
                value[cpl.entry_idx] <= cpl.value;
                mis_pred[cpl.entry_idx] <= cpl.mis_pred;
            end
            if (retire) begin
                head <= head + 1'b1;
            end
            count <= count + CNT_W'(dsp.fire) - CNT_W'(retire);
        end
    end

endmodule

`default_nettype wire

// ==== hw/alu_unit.sv ====
`default_nettype none

module alu_unit (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    squash,
    input  logic                    issue_valid,
    input  ooo_ctrl_pkg::alu_op_t   issue_op,
    input  ooo_data_pkg::word_t     issue_a,
    input  ooo_data_pkg::word_t     issue_b,
    input  ooo_data_pkg::rob_idx_t  issue_tag,
    complete_if.source              cpl
);
    import ooo_data_pkg::*;
    import ooo_ctrl_pkg::*;

    word_t result;
    logic  mispredict;

    always_comb begin
        case (issue_op)
            op_add:  result = issue_a + issue_b;
            op_sub:  result = issue_a - issue_b;
            op_xor:  result = issue_a ^ issue_b;
            default: result = '0;       // A branch has no result.
        endcase
    end

    // Static prediction is not taken, so a taken bne is a misprediction.
    assign mispredict = (issue_op == op_bne) && (issue_a != issue_b);

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            cpl.completed <= 1'b0;
        end else begin
            cpl.completed <= issue_valid;
        end
        cpl.entry_idx <= issue_tag;
        cpl.value <= result;
        cpl.mis_pred <= mispredict;
    end

endmodule

`default_nettype wire

// ==== hw/reservation_station.sv ====
`default_nettype none

`include "ooo_macros.svh"

module reservation_station (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    squash,
    dispatch_if.sink                dsp,
    complete_if.sink                cpl,
    output logic                    issue_valid,
    output ooo_ctrl_pkg::alu_op_t   issue_op,
    output ooo_data_pkg::word_t     issue_a,
    output ooo_data_pkg::word_t     issue_b,
    output ooo_data_pkg::rob_idx_t  issue_tag,
    output logic                    rs_full
);
    import ooo_data_pkg::*;
    import ooo_ctrl_pkg::*;

    localparam int IDX_W = $clog2(`RS_SIZE);

    slot_state_t      state [`RS_SIZE];
    logic [IDX_W-1:0] age [`RS_SIZE];      // Zero is the youngest occupied slot.
    alu_op_t          op [`RS_SIZE];
    rob_idx_t         dst_tag [`RS_SIZE];
    word_t            val_a [`RS_SIZE];
    word_t            val_b [`RS_SIZE];
    rob_idx_t         tag_a [`RS_SIZE];
    rob_idx_t         tag_b [`RS_SIZE];
    logic             pend_a [`RS_SIZE];
    logic             pend_b [`RS_SIZE];
    logic             wake_a [`RS_SIZE];
    logic             wake_b [`RS_SIZE];
    logic [IDX_W-1:0] free_idx;
    logic [IDX_W-1:0] issue_idx;
    logic             has_free;
    logic             wake1;
    logic             wake2;

    always_comb begin
        has_free = 1'b0;
        free_idx = '0;
        issue_valid = 1'b0;
        issue_idx = '0;
        for (int i = `RS_SIZE - 1; i >= 0; i--) begin
            if (state[i] == slot_free) begin
                has_free = 1'b1;
                free_idx = IDX_W'(i);           // Lowest free slot wins.
            end
        end
        for (int i = 0; i < `RS_SIZE; i++) begin
            wake_a[i] = cpl.completed && pend_a[i] && tag_a[i] == cpl.entry_idx;
            wake_b[i] = cpl.completed && pend_b[i] && tag_b[i] == cpl.entry_idx;
            if (state[i] == slot_ready && (!issue_valid || age[i] > age[issue_idx])) begin
                issue_valid = 1'b1;
                issue_idx = IDX_W'(i);
            end
        end
    end

    // Wakeup of the instruction that dispatches in this very cycle.
    assign wake1 = cpl.completed && dsp.src1_pending && dsp.src1_tag == cpl.entry_idx;
    assign wake2 = cpl.completed && dsp.src2_pending && dsp.src2_tag == cpl.entry_idx;

    assign rs_full = !has_free;
    assign issue_op = op[issue_idx];
    assign issue_a = val_a[issue_idx];
    assign issue_b = val_b[issue_idx];
    assign issue_tag = dst_tag[issue_idx];

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            for (int i = 0; i < `RS_SIZE; i++) begin
                state[i] <= slot_free;
                age[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `RS_SIZE; i++) begin
                if (state[i] == slot_waiting) begin
                    if (wake_a[i]) begin
                        val_a[i] <= cpl.value;
                        pend_a[i] <= 1'b0;
                    end
                    if (wake_b[i]) begin
                        val_b[i] <= cpl.value;
                        pend_b[i] <= 1'b0;
                    end
                    if ((!pend_a[i] || wake_a[i]) && (!pend_b[i] || wake_b[i])) begin
                        state[i] <= slot_ready;
                    end
                end
                // Keep ages dense so they stay unique within IDX_W bits.
                if (state[i] != slot_free) begin
                    age[i] <= age[i] + IDX_W'(dsp.fire)
                              - IDX_W'(issue_valid && age[i] > age[issue_idx]);
                end
            end
            if (issue_valid) begin
                state[issue_idx] <= slot_free;
            end
            if (dsp.fire) begin
                state[free_idx] <= ((dsp.src1_pending && !wake1) || (dsp.src2_pending && !wake2))
                                   ? slot_waiting : slot_ready;
                age[free_idx] <= '0;
                op[free_idx] <= dsp.op;
                dst_tag[free_idx] <= dsp.rob_tag;
                val_a[free_idx] <= wake1 ? cpl.value : dsp.src1_value;
                val_b[free_idx] <= wake2 ? cpl.value : dsp.src2_value;
                tag_a[free_idx] <= dsp.src1_tag;
                tag_b[free_idx] <= dsp.src2_tag;
                pend_a[free_idx] <= dsp.src1_pending && !wake1;
                pend_b[free_idx] <= dsp.src2_pending && !wake2;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/arch_regfile.sv ====
`default_nettype none

`include "ooo_macros.svh"

module arch_regfile (
    input  logic                    clock,
    input  logic                    reset,
    commit_if.sink                  cmt,
    input  ooo_data_pkg::reg_idx_t  src1,
    input  ooo_data_pkg::reg_idx_t  src2,
    output ooo_data_pkg::word_t     reg_value1,
    output ooo_data_pkg::word_t     reg_value2
);
    import ooo_data_pkg::*;

    word_t regs [`REG_COUNT];

    assign reg_value1 = regs[src1];
    assign reg_value2 = regs[src2];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (cmt.dest_valid) begin
            regs[cmt.dest_reg_idx] <= cmt.dest_value;   // Never register zero.
        end
    end

endmodule

`default_nettype wire

// ==== hw/map_table.sv ====
`default_nettype none

`include "ooo_macros.svh"

module map_table (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    squash,
    dispatch_if.sink                dsp,
    commit_if.sink                  cmt,
    input  ooo_data_pkg::reg_idx_t  src1,
    input  ooo_data_pkg::reg_idx_t  src2,
    output ooo_data_pkg::rob_idx_t  map_tag1,
    output ooo_data_pkg::rob_idx_t  map_tag2,
    output logic                    map_hit1,
    output logic                    map_hit2
);
    import ooo_data_pkg::*;

    logic [`REG_COUNT-1:0] mapped;
    rob_idx_t              tags [`REG_COUNT];

    assign map_hit1 = mapped[src1];
    assign map_hit2 = mapped[src2];
    assign map_tag1 = tags[src1];
    assign map_tag2 = tags[src2];

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            mapped <= '0;
        end else begin
            // The youngest writer may have renamed the register again.
            if (cmt.dest_valid && tags[cmt.dest_reg_idx] == cmt.head_idx) begin
                mapped[cmt.dest_reg_idx] <= 1'b0;
            end
            if (dsp.fire && dsp.dest != `ZERO_REG) begin
                mapped[dsp.dest] <= 1'b1;       // Overrides a commit to the same register.
                tags[dsp.dest] <= dsp.rob_tag;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/dispatch_unit.sv ====
`default_nettype none

`include "ooo_macros.svh"

module dispatch_unit (
    input  logic                    valid,
    input  ooo_data_pkg::pc_t       pc,
    input  ooo_ctrl_pkg::alu_op_t   op,
    input  ooo_data_pkg::reg_idx_t  dest,
    input  ooo_data_pkg::reg_idx_t  src1,
    input  ooo_data_pkg::reg_idx_t  src2,
    input  ooo_data_pkg::rob_idx_t  map_tag1,
    input  ooo_data_pkg::rob_idx_t  map_tag2,
    input  logic                    map_hit1,
    input  logic                    map_hit2,
    input  ooo_data_pkg::word_t     reg_value1,
    input  ooo_data_pkg::word_t     reg_value2,
    input  logic                    rob_ready1,
    input  logic                    rob_ready2,
    input  ooo_data_pkg::word_t     rob_value1,
    input  ooo_data_pkg::word_t     rob_value2,
    input  logic                    rob_full,
    input  logic                    rs_full,
    input  logic                    squash,
    output logic                    stall,
    dispatch_if.source              dsp
);
    import ooo_data_pkg::*;
    import ooo_ctrl_pkg::*;

    // A source waits only on a mapped, still unfinished producer.
    function automatic logic is_pending(input reg_idx_t src, input logic hit,
                                        input logic ready);
        return (src != `ZERO_REG) && hit && !ready;
    endfunction

    // Unmapped registers read the register file; otherwise the ROB copy is taken.
    function automatic word_t pick_value(input reg_idx_t src, input logic hit,
                                         input word_t reg_value, input word_t rob_value);
        if (src == `ZERO_REG || !hit) begin
            return reg_value;
        end
        return rob_value;
    endfunction

    assign stall = rob_full | rs_full;
    assign dsp.fire = valid && !stall && !squash;   // Dropped while squashing.

    assign dsp.pc = pc;
    assign dsp.op = op;
    assign dsp.dest = (op == op_bne) ? `ZERO_REG : dest; // A branch writes nothing.

    assign dsp.src1_tag = map_tag1;
    assign dsp.src1_pending = is_pending(src1, map_hit1, rob_ready1);
    assign dsp.src1_value = pick_value(src1, map_hit1, reg_value1, rob_value1);

    assign dsp.src2_tag = map_tag2;
    assign dsp.src2_pending = is_pending(src2, map_hit2, rob_ready2);
    assign dsp.src2_value = pick_value(src2, map_hit2, reg_value2, rob_value2);

endmodule

`default_nettype wire

// ==== hw/ooo_ifs.sv ====
`default_nettype none

interface dispatch_if;
    import ooo_data_pkg::*;
    import ooo_ctrl_pkg::*;

    logic     fire;
    pc_t      pc;
    alu_op_t  op;
    reg_idx_t dest;
    rob_idx_t rob_tag;          // Tail of the ROB, driven by the ROB itself.
    rob_idx_t src1_tag;
    logic     src1_pending;
    word_t    src1_value;
    rob_idx_t src2_tag;
    logic     src2_pending;
    word_t    src2_value;

    modport source (output fire, pc, op, dest, src1_tag, src1_pending, src1_value,
                    src2_tag, src2_pending, src2_value);
    modport rob_side (input fire, pc, dest, output rob_tag);
    modport sink (input fire, op, dest, rob_tag, src1_tag, src1_pending, src1_value,
                  src2_tag, src2_pending, src2_value);
endinterface

interface complete_if;
    import ooo_data_pkg::*;

    logic     completed;
    rob_idx_t entry_idx;
    word_t    value;
    logic     mis_pred;

    modport source (output completed, entry_idx, value, mis_pred);
    modport sink (input completed, entry_idx, value, mis_pred);
endinterface

interface commit_if;
    import ooo_data_pkg::*;

    logic     dest_valid;
    reg_idx_t dest_reg_idx;
    word_t    dest_value;
    rob_idx_t head_idx;

    modport source (output dest_valid, dest_reg_idx, dest_value, head_idx);
    modport sink (input dest_valid, dest_reg_idx, dest_value, head_idx);
endinterface

`default_nettype wire

// ==== hw/ooo_ctrl_pkg.sv ====
`default_nettype none

package ooo_ctrl_pkg;

    typedef enum logic [1:0] {
        op_add,
        op_sub,
        op_xor,
        op_bne                  // Predicted not taken.
    } alu_op_t;

    typedef enum logic [1:0] {
        slot_free,
        slot_waiting,           // At least one operand still pending.
        slot_ready
    } slot_state_t;

endpackage

`default_nettype wire

// ==== hw/ooo_data_pkg.sv ====
`default_nettype none

`include "ooo_macros.svh"

package ooo_data_pkg;

    typedef logic [`XLEN-1:0] word_t;           // One data value.

    typedef logic [4:0] reg_idx_t;              // Architectural register number.

    typedef logic [`ROB_IDX_LEN-1:0] rob_idx_t; // Reorder-buffer entry tag.

    typedef logic [31:0] pc_t;                  // Instruction address.

endpackage

`default_nettype wire

// ==== hw/ooo_macros.svh ====
`ifndef OOO_MACROS_SVH
`define OOO_MACROS_SVH

// Datapath and register file sizes.
`define XLEN 32
`define REG_COUNT 32
`define ZERO_REG 5'd0

// Window sizes. ROB_SIZE must equal 2**ROB_IDX_LEN so that the indices wrap naturally.
`define ROB_SIZE 8
`define ROB_IDX_LEN 3
`define RS_SIZE 4

`endif
